//--- lsq_defines.svh
// ----------------------------------------
// global sizing macros for the load/store
// queue subsystem, include wherever the
// data width, fifo depth or ram size is used
// ----------------------------------------

`ifndef LSQ_DEFINES_SVH
`define LSQ_DEFINES_SVH

// data and address width, one word
`define LSQ_XLEN 32

// default entries per fifo
`define LSQ_FIFO_DEPTH 4

// scratch ram words, byte addresses from 4x this value fault
`define LSQ_RAM_WORDS 64

`endif

//--- lsq_pkg.sv
// ----------------------------------------
// shared types of the load/store queue
// data port, execution push and write-back
// ----------------------------------------

`include "lsq_defines.svh"

package lsq_pkg;

    // access size, low two bits of funct3
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } size_t;

    // one payload word, read per request direction
    typedef union packed {
        logic [`LSQ_XLEN-1:0] store_data;   // replicated store data
        struct packed {
            logic [`LSQ_XLEN-6:0] pad;
            logic [4:0]           regd;     // load destination
        } load;
    } req_payload_u;

    typedef struct packed {
        logic                 lq_wr;
        logic                 sq_wr;
        logic [2:0]           funct3;
        logic [4:0]           regd;
        logic [`LSQ_XLEN-1:0] rs2_data;
        logic [`LSQ_XLEN-1:0] addr;
    } exs_req_t;

    typedef struct packed {
        logic [`LSQ_XLEN-1:0] addr;
        req_payload_u         payload;
        logic [2:0]           funct3;
        logic                 write;
    } req_entry_t;

    typedef struct packed {
        logic                 write;
        size_t                size;
        logic [`LSQ_XLEN-1:0] addr;
        logic [`LSQ_XLEN-1:0] data;
    } dreq_t;

    typedef struct packed {
        logic                 rerr;
        logic                 werr;
        logic [`LSQ_XLEN-1:0] data;
    } drsp_t;

    // kept per outstanding load
    typedef struct packed {
        logic [1:0] offset;
        logic [4:0] regd;
        logic [2:0] funct3;
    } rsp_ctrl_t;

    typedef struct packed {
        logic [4:0]           regd;
        logic [`LSQ_XLEN-1:0] data;
    } wb_t;

endpackage

//--- lsq_fifo.sv
// ----------------------------------------
// synchronous fifo with registered pointers
// head entry shows on dout_o while not empty
// ----------------------------------------

`include "lsq_defines.svh"

module lsq_fifo #(
    parameter int WIDTH = `LSQ_XLEN,
    parameter int DEPTH = `LSQ_FIFO_DEPTH
) (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             wr_i,
    input  logic [WIDTH-1:0] din_i,
    input  logic             rd_i,
    output logic [WIDTH-1:0] dout_o,
    output logic             empty_o,
    output logic             full_o
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_wr;
    logic             do_rd;

    assign empty_o = (count == '0);
    assign full_o  = (count == CW'(DEPTH));
    assign do_wr   = wr_i & ~full_o;
    assign do_rd   = rd_i & ~empty_o;
    assign dout_o  = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr] <= din_i;
        end
    end

    // pointers wrap at DEPTH so any depth works
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(do_wr) - CW'(do_rd);
        end
    end

endmodule

//--- lsq_load_formatter.sv
// ----------------------------------------
// justifies a returned load word by its
// byte offset and extends it per funct3
// ----------------------------------------

`include "lsq_defines.svh"

module lsq_load_formatter (
    input  logic [`LSQ_XLEN-1:0] raw_i,
    input  lsq_pkg::rsp_ctrl_t   ctrl_i,
    output logic [`LSQ_XLEN-1:0] data_o
);
    logic [`LSQ_XLEN-1:0] justified;

    // addressed byte or half moved to bit 0
    assign justified = raw_i >> {ctrl_i.offset, 3'b000};

    always_comb begin
        case (ctrl_i.funct3)
            3'b000: begin   // lb
                data_o = {{(`LSQ_XLEN-8){justified[7]}}, justified[7:0]};
            end
            3'b001: begin   // lh
                data_o = {{(`LSQ_XLEN-16){justified[15]}}, justified[15:0]};
            end
            3'b100: begin   // lbu
                data_o = {{(`LSQ_XLEN-8){1'b0}}, justified[7:0]};
            end
            3'b101: begin   // lhu
                data_o = {{(`LSQ_XLEN-16){1'b0}}, justified[15:0]};
            end
            default: begin
                data_o = justified;   // lw
            end
        endcase
    end

endmodule

//--- lsq_queue.sv
// ----------------------------------------
// load/store queue between execution stage
// and a valid/ready data port, loads write
// back in order, faults leave as pulses
// ----------------------------------------

`include "lsq_defines.svh"

module lsq_queue (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    // execution stage
    input  lsq_pkg::exs_req_t    exs_wr_i,
    output logic                 exs_full_o,
    output logic                 exs_empty_o,
    // data port
    output lsq_pkg::dreq_t       dreq_o,
    output logic                 dreqvalid_o,
    input  logic                 dreqready_i,
    input  lsq_pkg::drsp_t       drsp_i,
    input  logic                 drspvalid_i,
    output logic                 drspready_o,
    // register write-back
    output logic                 wb_valid_o,
    output lsq_pkg::wb_t         wb_o,
    // imprecise faults
    output logic                 fault_load_o,
    output logic                 fault_store_o,
    output logic [`LSQ_XLEN-1:0] fault_data_o
);
    logic                 req_push;
    logic                 req_xfer;
    logic                 req_empty;
    logic [`LSQ_XLEN-1:0] store_repl;
    lsq_pkg::req_entry_t  req_in;
    lsq_pkg::req_entry_t  req_out;
    lsq_pkg::rsp_ctrl_t   ctrl_in;
    lsq_pkg::rsp_ctrl_t   ctrl_out;
    logic                 ctrl_empty;
    logic                 ctrl_full;
    logic                 rsp_is_store;
    logic [`LSQ_XLEN-1:0] data_in;
    logic [`LSQ_XLEN-1:0] data_out;
    logic                 data_empty;
    logic                 data_full;

    // ----------------------------------------
    // request side
    // ----------------------------------------
    assign req_push = exs_wr_i.lq_wr | exs_wr_i.sq_wr;
    assign req_xfer = dreqvalid_o & dreqready_i;

    always_comb begin
        case (exs_wr_i.funct3[1:0])
            2'b00:   store_repl = {4{exs_wr_i.rs2_data[7:0]}};
            2'b01:   store_repl = {2{exs_wr_i.rs2_data[15:0]}};
            default: store_repl = exs_wr_i.rs2_data;
        endcase
    end

    always_comb begin
        req_in.addr   = exs_wr_i.addr;
        req_in.funct3 = exs_wr_i.funct3;
        req_in.write  = exs_wr_i.sq_wr;
        if (exs_wr_i.lq_wr) begin
            req_in.payload.load.pad  = '0;
            req_in.payload.load.regd = exs_wr_i.regd;
        end else begin
            req_in.payload.store_data = store_repl;
        end
    end

    lsq_fifo #(
        .WIDTH ($bits(lsq_pkg::req_entry_t))
    ) u_req_fifo (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .wr_i     (req_push),
        .din_i    (req_in),
        .rd_i     (req_xfer),
        .dout_o   (req_out),
        .empty_o  (req_empty),
        .full_o   (exs_full_o)
    );

    // stall issue while no room to track another load
    assign dreqvalid_o  = ~req_empty & ~ctrl_full;
    assign dreq_o.write = req_out.write;
    assign dreq_o.size  = lsq_pkg::size_t'(req_out.funct3[1:0]);
    assign dreq_o.addr  = req_out.addr;
    assign dreq_o.data  = req_out.payload.store_data;

    // ----------------------------------------
    // response side
    // ----------------------------------------
    assign ctrl_in.offset = req_out.addr[1:0];
    assign ctrl_in.regd   = req_out.payload.load.regd;
    assign ctrl_in.funct3 = req_out.funct3;

    lsq_fifo #(
        .WIDTH ($bits(lsq_pkg::rsp_ctrl_t))
    ) u_rsp_ctrl_fifo (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .wr_i     (req_xfer & ~req_out.write),
        .din_i    (ctrl_in),
        .rd_i     (wb_valid_o),
        .dout_o   (ctrl_out),
        .empty_o  (ctrl_empty),
        .full_o   (ctrl_full)
    );

    // direction of the request in flight, one response at a time on this port
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_is_store <= 1'b0;
        end else if (req_xfer) begin
            rsp_is_store <= req_out.write;
        end
    end

    assign drspready_o = drspvalid_i & (~data_full | rsp_is_store);
    assign data_in     = drsp_i.rerr ? '0 : drsp_i.data;   // zero on read error

    lsq_fifo #(
        .WIDTH (`LSQ_XLEN)
    ) u_rsp_data_fifo (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .wr_i     (drspready_o & ~rsp_is_store),
        .din_i    (data_in),
        .rd_i     (wb_valid_o),
        .dout_o   (data_out),
        .empty_o  (data_empty),
        .full_o   (data_full)
    );

    assign wb_valid_o  = ~data_empty;   // no back-pressure from regfile
    assign wb_o.regd   = ctrl_out.regd;
    assign exs_empty_o = req_empty & ctrl_empty;

    lsq_load_formatter u_formatter (
        .raw_i  (data_out),
        .ctrl_i (ctrl_out),
        .data_o (wb_o.data)
    );

    assign fault_load_o  = drspready_o & drsp_i.rerr;
    assign fault_store_o = drspready_o & drsp_i.werr;
    assign fault_data_o  = drsp_i.data;

endmodule

//--- lsq_scratch_ram.sv
// ----------------------------------------
// word-addressed scratch ram on the data port
// byte strobes from size, out of range faults
// ----------------------------------------

`include "lsq_defines.svh"

module lsq_scratch_ram (
    input  logic           clk_i,
    input  logic           arst_n_i,
    input  lsq_pkg::dreq_t dreq_i,
    input  logic           dreqvalid_i,
    output logic           dreqready_o,
    output lsq_pkg::drsp_t drsp_o,
    output logic           drspvalid_o,
    input  logic           drspready_i
);
    localparam int RAM_AW = $clog2(`LSQ_RAM_WORDS);
    localparam logic [`LSQ_XLEN-1:0] RAM_BYTES = `LSQ_XLEN'(`LSQ_RAM_WORDS * 4);

    logic [`LSQ_XLEN-1:0] mem [`LSQ_RAM_WORDS];
    logic [RAM_AW-1:0]    idx;
    logic                 in_range;
    logic                 accept;
    logic [3:0]           strobe;

    assign idx         = dreq_i.addr[RAM_AW+1:2];
    assign in_range    = dreq_i.addr < RAM_BYTES;
    assign dreqready_o = ~drspvalid_o | drspready_i;   // busy while a response waits
    assign accept      = dreqvalid_i & dreqready_o;

    always_comb begin
        case (dreq_i.size)
            lsq_pkg::SIZE_BYTE: strobe = 4'b0001 << dreq_i.addr[1:0];
            lsq_pkg::SIZE_HALF: strobe = 4'b0011 << {dreq_i.addr[1], 1'b0};
            lsq_pkg::SIZE_WORD: strobe = 4'b1111;
            default:            strobe = 4'b0000;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (accept && dreq_i.write && in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (strobe[b]) begin
                    mem[idx][8*b +: 8] <= dreq_i.data[8*b +: 8];
                end
            end
        end
    end

    // one-cycle response, held until taken
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            drspvalid_o <= 1'b0;
            drsp_o      <= '0;
        end else if (accept) begin
            drspvalid_o <= 1'b1;
            drsp_o.rerr <= ~dreq_i.write & ~in_range;
            drsp_o.werr <= dreq_i.write & ~in_range;
            drsp_o.data <= (~dreq_i.write && in_range) ? mem[idx] : '0;
        end else if (drspready_i) begin
            drspvalid_o <= 1'b0;
        end
    end

endmodule

//--- lsq_top.sv
// ----------------------------------------
// load/store queue with its scratch ram
// exposes the execution and write-back ports
// ----------------------------------------

`include "lsq_defines.svh"

module lsq_top (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  lsq_pkg::exs_req_t    exs_wr_i,
    output logic                 exs_full_o,
    output logic                 exs_empty_o,
    output logic                 wb_valid_o,
    output lsq_pkg::wb_t         wb_o,
    output logic                 fault_load_o,
    output logic                 fault_store_o,
    output logic [`LSQ_XLEN-1:0] fault_data_o
);
    lsq_pkg::dreq_t dreq;
    logic           dreqvalid;
    logic           dreqready;
    lsq_pkg::drsp_t drsp;
    logic           drspvalid;
    logic           drspready;

    lsq_queue u_queue (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .exs_wr_i      (exs_wr_i),
        .exs_full_o    (exs_full_o),
        .exs_empty_o   (exs_empty_o),
        .dreq_o        (dreq),
        .dreqvalid_o   (dreqvalid),
        .dreqready_i   (dreqready),
        .drsp_i        (drsp),
        .drspvalid_i   (drspvalid),
        .drspready_o   (drspready),
        .wb_valid_o    (wb_valid_o),
        .wb_o          (wb_o),
        .fault_load_o  (fault_load_o),
        .fault_store_o (fault_store_o),
        .fault_data_o  (fault_data_o)
    );

    lsq_scratch_ram u_ram (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .dreq_i      (dreq),
        .dreqvalid_i (dreqvalid),
        .dreqready_o (dreqready),
        .drsp_o      (drsp),
        .drspvalid_o (drspvalid),
        .drspready_i (drspready)
    );

endmodule

//--- lsq_sva.sv
// ----------------------------------------
// protocol checks on the lsq subsystem ports
// bound into lsq_top, counts every failure
// ----------------------------------------

module lsq_sva (
    input logic              clk_i,
    input logic              arst_n_i,
    input lsq_pkg::exs_req_t exs_wr_i,
    input logic              exs_full_o,
    input logic              exs_empty_o,
    input logic              wb_valid_o,
    input logic              fault_load_o,
    input logic              fault_store_o
);
    int unsigned fail_count = 0;   // read by the testbench

    push_not_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (exs_wr_i.lq_wr || exs_wr_i.sq_wr) |-> !exs_full_o)
        else begin
            fail_count++;
            $error("request pushed while the queue was full");
        end

    faults_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(fault_load_o && fault_store_o))
        else begin
            fail_count++;
            $error("load and store fault pulses in the same cycle");
        end

    no_wb_when_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        exs_empty_o |-> !wb_valid_o)
        else begin
            fail_count++;
            $error("write-back valid while the queue reports empty");
        end

    // every output at its reset value
    idle_in_reset: assert property (@(posedge clk_i)
        !arst_n_i |-> (!wb_valid_o && !fault_load_o && !fault_store_o
                       && !exs_full_o && exs_empty_o))
        else begin
            fail_count++;
            $error("outputs not idle during reset");
        end

endmodule

bind lsq_top lsq_sva u_sva (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .exs_wr_i      (exs_wr_i),
    .exs_full_o    (exs_full_o),
    .exs_empty_o   (exs_empty_o),
    .wb_valid_o    (wb_valid_o),
    .fault_load_o  (fault_load_o),
    .fault_store_o (fault_store_o)
);

//--- tb_lsq.sv
// ----------------------------------------
// testbench for lsq_top, directed and random
// accesses against a byte model of the ram
// write-backs and faults checked at negedge
// ----------------------------------------

`include "lsq_defines.svh"

module tb_lsq;
    localparam logic [`LSQ_XLEN-1:0] RAM_BYTES = `LSQ_XLEN'(`LSQ_RAM_WORDS * 4);
    localparam int WAIT_LIMIT = 2000;

    logic                 clk_i;
    logic                 arst_n_i;
    lsq_pkg::exs_req_t    exs_wr_i;
    logic                 exs_full_o;
    logic                 exs_empty_o;
    logic                 wb_valid_o;
    lsq_pkg::wb_t         wb_o;
    logic                 fault_load_o;
    logic                 fault_store_o;
    logic [`LSQ_XLEN-1:0] fault_data_o;

    logic [7:0]   mem_model [`LSQ_RAM_WORDS * 4];
    lsq_pkg::wb_t exp_wb [$];
    logic         exp_fault [$];   // 1 marks a store fault
    string        test_name;
    logic [2:0]   ext_f3 [4] = '{3'b000, 3'b001, 3'b100, 3'b101};

    lsq_top DUT (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .exs_wr_i      (exs_wr_i),
        .exs_full_o    (exs_full_o),
        .exs_empty_o   (exs_empty_o),
        .wb_valid_o    (wb_valid_o),
        .wb_o          (wb_o),
        .fault_load_o  (fault_load_o),
        .fault_store_o (fault_store_o),
        .fault_data_o  (fault_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_value(input string test, input logic [63:0] want,
                                input logic [63:0] got);
        abort_run($sformatf("** Error %s: expected %h, actual %h", test, want, got));
    endtask

    function automatic int access_bytes(input logic [2:0] f3);
        return (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
    endfunction

    function automatic logic [`LSQ_XLEN-1:0] fill_word(input logic [`LSQ_XLEN-1:0] a);
        return (a * 32'h0104_0361) ^ 32'h5a5a_a5a5;
    endfunction

    // stores land on naturally aligned lanes
    function automatic void model_store(input logic [`LSQ_XLEN-1:0] addr,
                                        input logic [2:0] f3,
                                        input logic [`LSQ_XLEN-1:0] data);
        logic [`LSQ_XLEN-1:0] base;
        base = addr;
        if (f3[1:0] == 2'b01) base[0] = 1'b0;
        if (f3[1:0] == 2'b10) base[1:0] = 2'b00;
        if (addr < RAM_BYTES) begin
            for (int k = 0; k < access_bytes(f3); k++) begin
                mem_model[base + k] = data[8*k +: 8];
            end
        end
    endfunction

    function automatic logic [`LSQ_XLEN-1:0] expect_load(input logic [`LSQ_XLEN-1:0] addr,
                                                        input logic [2:0] f3);
        logic [`LSQ_XLEN-1:0] v;
        int                   n;
        v = '0;
        n = access_bytes(f3);
        if (addr < RAM_BYTES) begin
            for (int k = 0; k < n; k++) begin
                if (int'(addr[1:0]) + k < 4) v[8*k +: 8] = mem_model[addr + k];   // past word is 0
            end
        end
        if (!f3[2] && n == 1) v = {{(`LSQ_XLEN-8){v[7]}}, v[7:0]};
        if (!f3[2] && n == 2) v = {{(`LSQ_XLEN-16){v[15]}}, v[15:0]};
        return v;
    endfunction

    // one access, issued once the queue has room
    task automatic push_access(input logic st, input logic [2:0] f3, input logic [4:0] rd,
                               input logic [`LSQ_XLEN-1:0] data,
                               input logic [`LSQ_XLEN-1:0] addr);
        lsq_pkg::exs_req_t req;
        lsq_pkg::wb_t      want;
        int                waited;
        waited = 0;
        @(negedge clk_i);
        while (exs_full_o) begin
            waited++;
            if (waited > WAIT_LIMIT) abort_run("timeout waiting for room in the queue");
            @(negedge clk_i);
        end
        req = '{lq_wr: !st, sq_wr: st, funct3: f3, regd: rd, rs2_data: data, addr: addr};
        if (addr >= RAM_BYTES) exp_fault.push_back(st);
        if (st) begin
            model_store(addr, f3, data);
        end else begin
            want.regd = rd;
            want.data = expect_load(addr, f3);
            exp_wb.push_back(want);
        end
        @(posedge clk_i);
        exs_wr_i <= req;
        @(posedge clk_i);
        exs_wr_i <= '0;
    endtask

    // write-back checker
    always @(negedge clk_i) begin
        lsq_pkg::wb_t want;
        if (arst_n_i && wb_valid_o) begin
            if (exp_wb.size() == 0) begin
                abort_run("write-back seen with no load outstanding");
            end else begin
                want = exp_wb.pop_front();
                wb_match: assert (wb_o == want)
                    else report_value(test_name, 64'(want), 64'(wb_o));
            end
        end
    end

    always @(negedge clk_i) begin
        logic want_store;
        if (arst_n_i && (fault_load_o || fault_store_o)) begin
            if (exp_fault.size() == 0) begin
                abort_run("access fault with no out-of-range access pending");
            end else begin
                want_store = exp_fault.pop_front();
                fault_kind: assert (fault_store_o == want_store && fault_load_o == !want_store)
                    else report_value({test_name, " fault"}, 64'(want_store), 64'(fault_store_o));
                fault_zero: assert (want_store || fault_data_o == '0)
                    else report_value({test_name, " fault data"}, 64'(0), 64'(fault_data_o));
            end
        end
    end

    always @(negedge clk_i) begin
        if (DUT.u_sva.fail_count != 0) abort_run("protocol assertion failed");
    end

    initial begin
        logic [`LSQ_XLEN-1:0] a;
        logic [2:0]           f3;
        logic                 st;
        int                   waited;
        void'($urandom(32'ha3f5_7025));
        arst_n_i  = 1'b0;
        exs_wr_i  = '0;
        test_name = "reset";
        repeat (10) @(posedge clk_i);
        arst_n_i <= 1'b1;

        // ----------------------------------------
        test_name = "word";
        for (int i = 0; i < `LSQ_RAM_WORDS; i++) begin
            push_access(1'b1, 3'b010, 5'd0, fill_word(32'(4 * i)), 32'(4 * i));
        end
        for (int i = 0; i < `LSQ_RAM_WORDS; i++) begin
            push_access(1'b0, 3'b010, 5'(i), '0, 32'(4 * i));
        end

        test_name = "subword";
        for (int b = 0; b < 4; b++) push_access(1'b1, 3'b000, 5'd0, $urandom, 32'(8'h40 + b));
        push_access(1'b1, 3'b001, 5'd0, $urandom, 32'h44);
        push_access(1'b1, 3'b001, 5'd0, $urandom, 32'h4a);
        push_access(1'b1, 3'b000, 5'd0, $urandom, 32'h4d);
        for (int w = 0; w < 4; w++) push_access(1'b0, 3'b010, 5'(w + 1), '0, 32'(8'h40 + 4 * w));

        test_name = "extend";
        push_access(1'b1, 3'b010, 5'd0, 32'h80f1_7f9e, 32'h80);
        push_access(1'b1, 3'b010, 5'd0, 32'h7f80_01ff, 32'h84);
        for (int off = 0; off < 8; off++) begin
            for (int k = 0; k < 4; k++) begin
                push_access(1'b0, ext_f3[k], 5'(8 * k + off), '0, 32'(8'h80 + off));
            end
        end

        test_name = "fault";
        push_access(1'b0, 3'b010, 5'd9, '0, RAM_BYTES);
        push_access(1'b1, 3'b010, 5'd0, 32'hc0de_f00d, RAM_BYTES + 32'h10);   // aliases word 4
        push_access(1'b0, 3'b010, 5'd10, '0, 32'h10);
        push_access(1'b0, 3'b100, 5'd11, '0, 32'hffff_fff1);

        // ----------------------------------------
        test_name = "burst";
        for (int n = 0; n < 200; n++) begin
            st = 1'($urandom_range(0, 1));
            a  = $urandom_range(0, RAM_BYTES + 15);
            f3 = st ? 3'($urandom_range(0, 2)) : ext_f3[$urandom_range(0, 3)];
            if (!st && $urandom_range(0, 4) == 0) f3 = 3'b010;
            if (f3[1:0] == 2'b01 && st) a[0] = 1'b0;
            if (f3[1:0] == 2'b10) a[1:0] = 2'b00;
            push_access(st, f3, 5'($urandom), $urandom, a);
        end

        test_name = "drain";
        waited = 0;
        @(negedge clk_i);
        while (!(exs_empty_o && exp_wb.size() == 0 && exp_fault.size() == 0)) begin
            waited++;
            if (waited > WAIT_LIMIT) abort_run("timeout waiting for the queue to drain");
            @(negedge clk_i);
        end

        if (exs_empty_o && DUT.u_sva.fail_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            abort_run("queue not idle or protocol errors at end of run");
        end
    end

endmodule

//--- project.f
+incdir+.
lsq_pkg.sv
lsq_fifo.sv
lsq_load_formatter.sv
lsq_queue.sv
lsq_scratch_ram.sv
lsq_top.sv
lsq_sva.sv
tb_lsq.sv

//--- run.sh
#!/bin/sh
# build the lsq testbench with verilator, then run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_lsq -f project.f -o sim_lsq
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_lsq +verilator+error+limit+100
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi
exit 0
